// ==== files.f ====
design/mem_bus_pkg.sv
design/fetch_pkg.sv
design/mem_req_if.sv
design/fetch_ctrl.sv
design/pc_counter.sv
design/fetch_buffer.sv
design/mem_arbiter.sv
design/fetch_top.sv
verification/fetch_props.sv
verification/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  # Packages
  - design/mem_bus_pkg.sv
  - design/fetch_pkg.sv
  # RTL
  - design/mem_req_if.sv
  - design/fetch_ctrl.sv
  - design/pc_counter.sv
  - design/fetch_buffer.sv
  - design/mem_arbiter.sv
  - design/fetch_top.sv
  # Testbench
  - target: test
    files:
      - verification/fetch_props.sv
      - verification/tb_fetch_top.sv

// ==== verification/tb_fetch_top.sv ====
// Testbench for the fetch front end with clock, reset, tagged memory model,
// stimulus table, compare tasks, timeout and summary
`timescale 1ns/1ps

module tb_fetch_top;

    // Word at address a is a xor this key
    localparam logic [31:0] WORD_KEY  = 32'h5a5a_0013;
    localparam int unsigned NUM_STEPS = 10;

    // One table row
    // redir 0 none, 1 at once, 2 with a line fetch in flight
    // op 0 none, 1 load, 2 store
    // line is the store data or the expected load line
    typedef struct {
        int unsigned  count;
        bit           stall;
        int unsigned  redir;
        logic [31:0]  target;
        int unsigned  op;
        logic [31:0]  addr;
        logic [63:0]  line;
    } step_t;

    logic                                 clock;
    logic                                 reset;
    mem_bus_pkg::mem_tag_t                mem_response;
    mem_bus_pkg::mem_tag_t                mem_tag;
    logic [mem_bus_pkg::LINE_BITS-1:0]    mem_data;
    mem_bus_pkg::bus_cmd_t                mem_cmd;
    logic [fetch_pkg::ADDR_BITS-1:0]      mem_addr;
    logic [mem_bus_pkg::LINE_BITS-1:0]    mem_wdata;
    logic                                 data_valid;
    logic                                 data_store;
    logic [fetch_pkg::ADDR_BITS-1:0]      data_addr;
    logic [mem_bus_pkg::LINE_BITS-1:0]    data_wdata;
    logic                                 data_ready;
    logic                                 load_valid;
    mem_bus_pkg::mem_line_u               load_data;
    logic                                 inst_ready;
    logic                                 inst_valid;
    fetch_pkg::fetch_packet_t             inst_packet;
    logic                                 redirect_valid;
    logic [fetch_pkg::ADDR_BITS-1:0]      redirect_pc;

    //////////////////////////////////////////////////
    // Memory model state
    //////////////////////////////////////////////////

    logic [63:0]            store_mem [bit [28:0]];
    mem_bus_pkg::mem_tag_t  next_tag;
    logic                   busy_rand;
    logic                   slot_taken;
    // One fetch and one load in flight at most
    logic                   fetch_slot_valid;
    mem_bus_pkg::mem_tag_t  fetch_slot_tag;
    logic [31:0]            fetch_slot_addr;
    int unsigned            fetch_wait;
    logic                   load_slot_valid;
    mem_bus_pkg::mem_tag_t  load_slot_tag;
    logic [31:0]            load_slot_addr;
    int unsigned            load_wait;
    // Request accepted at the last edge
    logic                   acc_valid;
    logic                   acc_store;
    logic                   acc_data;
    logic [31:0]            acc_addr;
    logic [63:0]            acc_wdata;
    mem_bus_pkg::mem_tag_t  acc_tag;

    // Scoreboard
    step_t                  steps [NUM_STEPS];
    logic [31:0]            exp_pc;
    int unsigned            taken;
    int unsigned            take_goal;
    logic                   after_redirect;
    // First slot of a line was just taken
    logic                   hit_due;
    logic                   seen_data_ready;
    logic                   seen_load_valid;
    mem_bus_pkg::mem_line_u seen_load_data;
    int unsigned            check_count;
    int unsigned            error_count;
    int unsigned            cycle_count = 0;
    int unsigned            cycle_limit = 200;

    fetch_top DUT (
        .clock          (clock),
        .reset          (reset),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .mem_cmd        (mem_cmd),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .data_valid     (data_valid),
        .data_store     (data_store),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_ready     (data_ready),
        .load_valid     (load_valid),
        .load_data      (load_data),
        .inst_ready     (inst_ready),
        .inst_valid     (inst_valid),
        .inst_packet    (inst_packet),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Busy on a random cycle or when that kind of request is already in flight
    assign slot_taken   = (mem_cmd == mem_bus_pkg::bus_load)
                       && (data_valid ? load_slot_valid : fetch_slot_valid);
    assign mem_response = (mem_cmd == mem_bus_pkg::bus_none || busy_rand || slot_taken)
                        ? '0 : next_tag;

    //////////////////////////////////////////////////
    // Model and checks
    //////////////////////////////////////////////////

    // Stored line or the address pattern for unwritten lines
    function automatic logic [63:0] line_at(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        if (store_mem.exists(addr[31:3])) begin
            return store_mem[addr[31:3]];
        end
        return {(base + 32'd4) ^ WORD_KEY, base ^ WORD_KEY};
    endfunction

    task automatic check_packet(input fetch_pkg::fetch_packet_t got,
                                input fetch_pkg::fetch_packet_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error @ %0t: packet pc %h inst %h, expected pc %h inst %h",
                     $time, got.pc, got.inst, exp.pc, exp.inst);
        end
    endtask

    task automatic check_line(input mem_bus_pkg::mem_line_u got,
                              input mem_bus_pkg::mem_line_u exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error @ %0t: load line %h, expected %h", $time, got.dword, exp.dword);
        end
    endtask

    // Sampled at the falling edge where DUT outputs have settled
    task automatic watch_outputs();
        fetch_pkg::fetch_packet_t exp;
        seen_data_ready = data_ready;
        seen_load_valid = load_valid;
        seen_load_data  = load_data;
        if (after_redirect) begin
            check_count++;
            if (inst_valid) begin
                error_count++;
                $display("error @ %0t: inst_valid high right after a redirect", $time);
            end
        end
        after_redirect = redirect_valid;
        // Second slot comes from the held line in the very next cycle
        if (hit_due) begin
            check_count++;
            if (!inst_valid) begin
                error_count++;
                $display("error @ %0t: second slot of the line not presented", $time);
            end
        end
        hit_due = 1'b0;
        // A transfer under redirect does not count
        if (inst_valid && inst_ready && !redirect_valid) begin
            exp.pc   = exp_pc;
            exp.inst = exp_pc ^ WORD_KEY;
            check_packet(inst_packet, exp);
            hit_due = !exp_pc[2];
            exp_pc  = exp_pc + 32'd4;
            taken++;
        end
        // Fetch kept off the bus while data is valid
        if (data_valid && mem_cmd == mem_bus_pkg::bus_load
            && (data_store || mem_addr != data_addr)) begin
            error_count++;
            $display("error @ %0t: instruction load at %h while data_valid", $time, mem_addr);
        end
        if (!reset && mem_response != '0) begin
            acc_valid = 1'b1;
            acc_store = (mem_cmd == mem_bus_pkg::bus_store);
            acc_data  = data_valid;
            acc_addr  = mem_addr;
            acc_wdata = mem_wdata;
            acc_tag   = mem_response;
        end
    endtask

    // Just after the rising edge
    task automatic drive_reply();
        if (fetch_slot_valid && fetch_wait > 0) begin
            fetch_wait--;
        end
        if (load_slot_valid && load_wait > 0) begin
            load_wait--;
        end
        mem_tag  = '0;
        mem_data = '0;
        // Fetch reply first and a due load waits one cycle
        if (fetch_slot_valid && fetch_wait == 0) begin
            mem_tag          = fetch_slot_tag;
            mem_data         = line_at(fetch_slot_addr);
            fetch_slot_valid = 1'b0;
        end else if (load_slot_valid && load_wait == 0) begin
            mem_tag         = load_slot_tag;
            mem_data        = line_at(load_slot_addr);
            load_slot_valid = 1'b0;
        end
        if (acc_valid) begin
            if (acc_store) begin
                store_mem[acc_addr[31:3]] = acc_wdata;
            end else if (acc_data) begin
                load_slot_valid = 1'b1;
                load_slot_tag   = acc_tag;
                load_slot_addr  = acc_addr;
                load_wait       = 2 + ($urandom % 4);
            end else begin
                fetch_slot_valid = 1'b1;
                fetch_slot_tag   = acc_tag;
                fetch_slot_addr  = acc_addr;
                fetch_wait       = 2 + ($urandom % 4);
            end
            next_tag  = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            acc_valid = 1'b0;
        end
        busy_rand = (($urandom % 8) == 0);
    endtask

    task automatic step_cycle(input bit stall);
        @(negedge clock);
        watch_outputs();
        @(posedge clock);
        #1;
        drive_reply();
        inst_ready = stall ? (($urandom % 4) != 0) : 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic fill_steps();
        steps[0] = '{6, 1'b0, 0, 32'h0, 0, 32'h0, 64'h0};
        steps[1] = '{9, 1'b1, 0, 32'h0, 0, 32'h0, 64'h0};
        steps[2] = '{4, 1'b0, 1, 32'h0000_0100, 0, 32'h0, 64'h0};
        steps[3] = '{5, 1'b1, 2, 32'h0000_0204, 0, 32'h0, 64'h0};
        steps[4] = '{4, 1'b0, 0, 32'h0, 1, 32'h0000_8000,
                     {32'h0000_8004 ^ WORD_KEY, 32'h0000_8000 ^ WORD_KEY}};
        steps[5] = '{4, 1'b1, 0, 32'h0, 2, 32'h0000_8010, 64'hdead_beef_0123_4567};
        // Same line as the store
        steps[6] = '{4, 1'b0, 0, 32'h0, 1, 32'h0000_8014, 64'hdead_beef_0123_4567};
        steps[7] = '{6, 1'b1, 2, 32'h0000_0040, 1, 32'h0000_8028,
                     {32'h0000_802c ^ WORD_KEY, 32'h0000_8028 ^ WORD_KEY}};
        steps[8] = '{3, 1'b0, 1, 32'h0000_0104, 2, 32'h0000_8030, 64'h0f1e_2d3c_4b5a_6978};
        steps[9] = '{8, 1'b1, 0, 32'h0, 1, 32'h0000_8030, 64'h0f1e_2d3c_4b5a_6978};
    endtask

    task automatic apply_step(input step_t s);
        mem_bus_pkg::mem_line_u exp_line;
        // Wait for a line request on the bus and then flush it
        if (s.redir == 2) begin
            do step_cycle(s.stall); while (!fetch_slot_valid);
        end
        if (s.redir != 0) begin
            redirect_valid = 1'b1;
            redirect_pc    = s.target;
            exp_pc         = s.target;
            step_cycle(s.stall);
            redirect_valid = 1'b0;
        end
        if (s.op != 0) begin
            data_valid = 1'b1;
            data_store = (s.op == 2);
            data_addr  = s.addr;
            data_wdata = s.line;
            do step_cycle(s.stall); while (!seen_data_ready);
            data_valid = 1'b0;
            data_store = 1'b0;
            if (s.op == 1) begin
                do step_cycle(s.stall); while (!seen_load_valid);
                exp_line.dword = s.line;
                check_line(seen_load_data, exp_line);
            end
        end
        take_goal += s.count;
        while (taken < take_goal) begin
            step_cycle(s.stall);
        end
    endtask

    initial begin
        void'($urandom(32'hc66b2a0e));
        reset            = 1'b1;
        inst_ready       = 1'b0;
        redirect_valid   = 1'b0;
        redirect_pc      = '0;
        data_valid       = 1'b0;
        data_store       = 1'b0;
        data_addr        = '0;
        data_wdata       = '0;
        mem_tag          = '0;
        mem_data         = '0;
        next_tag         = 4'h1;
        busy_rand        = 1'b0;
        fetch_slot_valid = 1'b0;
        load_slot_valid  = 1'b0;
        acc_valid        = 1'b0;
        exp_pc           = '0;
        taken            = 0;
        take_goal        = 0;
        after_redirect   = 1'b0;
        hit_due          = 1'b0;
        check_count      = 0;
        error_count      = 0;
        fill_steps();
        foreach (steps[i]) begin
            cycle_limit += steps[i].count * 12;
        end
        repeat (3) step_cycle(1'b0);
        reset = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        // Let late replies drain under the assertions
        repeat (8) step_cycle(1'b0);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/fetch_props.sv ====
// Bound checks on reset, data handshake, load replies
// and instruction hold
`timescale 1ns/1ps

module fetch_props (
    input logic                      clock,
    input logic                      reset,
    input mem_bus_pkg::bus_cmd_t     mem_cmd,
    input logic                      data_valid,
    input logic                      data_store,
    input logic                      data_ready,
    input logic                      load_valid,
    input logic                      inst_valid,
    input logic                      inst_ready,
    input logic                      redirect_valid,
    input fetch_pkg::fetch_packet_t  inst_packet
);

    // Load accepted and not yet answered
    logic load_open;

    always_ff @(posedge clock) begin
        if (reset) begin
            load_open <= 1'b0;
        end else if (load_valid) begin
            load_open <= 1'b0;
        end else if (data_ready && !data_store) begin
            load_open <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Bus and data port
    //////////////////////////////////////////////////

    // Bus stays idle through reset
    cmd_idle_in_reset: assert property (@(posedge clock)
        reset |=> mem_cmd == mem_bus_pkg::bus_none)
        else $error("bus command seen while reset is high");

    ready_needs_valid: assert property (@(posedge clock) disable iff (reset)
        data_ready |-> data_valid)
        else $error("data_ready high without data_valid");

    // Reply only for a load still owed
    reply_needs_load: assert property (@(posedge clock) disable iff (reset)
        load_valid |-> load_open)
        else $error("load_valid with no load pending");

    //////////////////////////////////////////////////
    // Instruction port
    //////////////////////////////////////////////////

    // Packet held until taken or flushed
    packet_holds: assert property (@(posedge clock) disable iff (reset)
        inst_valid && !inst_ready && !redirect_valid |=> inst_valid && $stable(inst_packet))
        else $error("instruction packet changed before it was taken");

endmodule

bind fetch_top fetch_props fetch_props_0 (
    .clock          (clock),
    .reset          (reset),
    .mem_cmd        (mem_cmd),
    .data_valid     (data_valid),
    .data_store     (data_store),
    .data_ready     (data_ready),
    .load_valid     (load_valid),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .redirect_valid (redirect_valid),
    .inst_packet    (inst_packet)
);

// ==== design/fetch_top.sv ====
// Fetch front end top: fetch controller, PC, line buffer and
// memory selector tied to the external bus and the data port
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [fetch_pkg::ADDR_BITS-1:0] RESET_PC = '0
) (
    input  logic                                 clock,
    input  logic                                 reset,
    // External memory bus
    input  mem_bus_pkg::mem_tag_t                mem_response,
    input  mem_bus_pkg::mem_tag_t                mem_tag,
    input  logic [mem_bus_pkg::LINE_BITS-1:0]    mem_data,
    output mem_bus_pkg::bus_cmd_t                mem_cmd,
    output logic [fetch_pkg::ADDR_BITS-1:0]      mem_addr,
    output logic [mem_bus_pkg::LINE_BITS-1:0]    mem_wdata,
    // Load and store port
    input  logic                                 data_valid,
    input  logic                                 data_store,
    input  logic [fetch_pkg::ADDR_BITS-1:0]      data_addr,
    input  logic [mem_bus_pkg::LINE_BITS-1:0]    data_wdata,
    output logic                                 data_ready,
    output logic                                 load_valid,
    output mem_bus_pkg::mem_line_u               load_data,
    // Instruction port
    input  logic                                 inst_ready,
    output logic                                 inst_valid,
    output fetch_pkg::fetch_packet_t             inst_packet,
    // Taken branch
    input  logic                                 redirect_valid,
    input  logic [fetch_pkg::ADDR_BITS-1:0]      redirect_pc
);

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    logic [fetch_pkg::ADDR_BITS-1:0] pc;
    logic                            pc_advance;
    logic                            pc_load;
    logic                            line_hit;
    logic                            buffer_fill;

    // Fetch side of the memory selector
    mem_req_if fetch_bus ();

    fetch_ctrl fetch_ctrl_0 (
        .clock          (clock),
        .reset          (reset),
        .bus            (fetch_bus.requester),
        .pc             (pc),
        .pc_advance     (pc_advance),
        .pc_load        (pc_load),
        .line_hit       (line_hit),
        .buffer_fill    (buffer_fill),
        .inst_ready     (inst_ready),
        .redirect_valid (redirect_valid),
        .inst_valid     (inst_valid)
    );

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) pc_counter_0 (
        .clock       (clock),
        .reset       (reset),
        .pc_advance  (pc_advance),
        .pc_load     (pc_load),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    // Line comes straight off the reply wires
    fetch_buffer fetch_buffer_0 (
        .clock       (clock),
        .reset       (reset),
        .buffer_fill (buffer_fill),
        .reply_line  (fetch_bus.reply_line),
        .pc          (pc),
        .line_hit    (line_hit),
        .inst_packet (inst_packet)
    );

    mem_arbiter mem_arbiter_0 (
        .clock        (clock),
        .reset        (reset),
        .fetch        (fetch_bus.bus),
        .data_valid   (data_valid),
        .data_store   (data_store),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_ready   (data_ready),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

// ==== design/mem_arbiter.sv ====
// Memory selector with data port priority over instruction fetch
// and tracking of the single outstanding load
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                 clock,
    input  logic                                 reset,
    mem_req_if.bus                               fetch,
    input  logic                                 data_valid,
    input  logic                                 data_store,
    input  logic [fetch_pkg::ADDR_BITS-1:0]      data_addr,
    input  logic [mem_bus_pkg::LINE_BITS-1:0]    data_wdata,
    output logic                                 data_ready,
    output logic                                 load_valid,
    output mem_bus_pkg::mem_line_u               load_data,
    input  mem_bus_pkg::mem_tag_t                mem_response,
    input  mem_bus_pkg::mem_tag_t                mem_tag,
    input  logic [mem_bus_pkg::LINE_BITS-1:0]    mem_data,
    output mem_bus_pkg::bus_cmd_t                mem_cmd,
    output logic [fetch_pkg::ADDR_BITS-1:0]      mem_addr,
    output logic [mem_bus_pkg::LINE_BITS-1:0]    mem_wdata
);

    logic                  load_pending;
    mem_bus_pkg::mem_tag_t load_tag;
    logic                  data_go;
    logic                  load_accepted;

    // Data port may only use the bus with no load outstanding
    assign data_go = data_valid && !load_pending;

    //////////////////////////////////////////////////
    // Bus select
    //////////////////////////////////////////////////

    // A valid data request holds fetch off the bus
    // even when it is itself blocked by a pending load
    always_comb begin
        if (data_valid) begin
            if (!data_go) begin
                mem_cmd = mem_bus_pkg::bus_none;
            end else if (data_store) begin
                mem_cmd = mem_bus_pkg::bus_store;
            end else begin
                mem_cmd = mem_bus_pkg::bus_load;
            end
            mem_addr  = data_addr;
            mem_wdata = data_wdata;
        end else begin
            mem_cmd   = fetch.cmd;
            mem_addr  = fetch.addr;
            mem_wdata = fetch.wdata.dword;
        end
    end

    // Accept tag goes to the winner only
    assign data_ready       = data_go && (mem_response != '0);
    assign fetch.accept_tag = data_valid ? '0 : mem_response;
    assign load_accepted    = data_ready && !data_store;

    //////////////////////////////////////////////////
    // Replies
    //////////////////////////////////////////////////

    // Same cycle as the tagged reply
    assign load_valid      = load_pending && (mem_tag == load_tag);
    assign load_data.dword = mem_data;

    // Any other tagged reply may belong to fetch
    assign fetch.reply_valid      = (mem_tag != '0) && !load_valid;
    assign fetch.reply_tag        = mem_tag;
    assign fetch.reply_line.dword = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else if (load_valid) begin
            load_pending <= 1'b0;
        end else if (load_accepted) begin
            load_pending <= 1'b1;
        end
    end

    // Tag of the accepted load
    always_ff @(posedge clock) begin
        if (load_accepted) begin
            load_tag <= mem_response;
        end
    end

endmodule

// ==== design/fetch_buffer.sv ====
// One-line fetch buffer: last fetched line and its address,
// line hit test and slot selection
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            buffer_fill,
    input  mem_bus_pkg::mem_line_u          reply_line,
    input  logic [fetch_pkg::ADDR_BITS-1:0] pc,
    output logic                            line_hit,
    output fetch_pkg::fetch_packet_t        inst_packet
);

    // Line address drops the 3 byte offset bits
    localparam int TAG_BITS = fetch_pkg::ADDR_BITS - 3;

    mem_bus_pkg::mem_line_u line;
    logic [TAG_BITS-1:0]    line_addr;
    logic                   line_valid;

    // Stored data and address
    always_ff @(posedge clock) begin
        if (buffer_fill) begin
            line      <= reply_line;
            line_addr <= pc[fetch_pkg::ADDR_BITS-1:3];
        end
    end

    // Valid mark survives redirects, the held line is still good data
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= 1'b0;
        end else if (buffer_fill) begin
            line_valid <= 1'b1;
        end
    end

    assign line_hit = line_valid && (line_addr == pc[fetch_pkg::ADDR_BITS-1:3]);

    // PC bit 2 picks the slot
    assign inst_packet.inst = line.slot[pc[2]];
    assign inst_packet.pc   = pc;

endmodule

// ==== design/pc_counter.sv ====
// Program counter with reset value, step and redirect load
`timescale 1ns/1ps

module pc_counter #(
    // Start address, 4-byte aligned
    parameter logic [fetch_pkg::ADDR_BITS-1:0] RESET_PC = '0
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            pc_advance,
    input  logic                            pc_load,
    input  logic [fetch_pkg::ADDR_BITS-1:0] redirect_pc,
    output logic [fetch_pkg::ADDR_BITS-1:0] pc
);

    // One instruction is four bytes
    localparam logic [fetch_pkg::ADDR_BITS-1:0] INST_BYTES = 4;

    // Load beats advance
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= redirect_pc;
        end else if (pc_advance) begin
            pc <= pc + INST_BYTES;
        end
    end

endmodule

// ==== design/fetch_ctrl.sv ====
// Fetch state machine: line requests, tag waits, delivery
// and redirect flushes
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                            clock,
    input  logic                            reset,
    mem_req_if.requester                    bus,
    input  logic [fetch_pkg::ADDR_BITS-1:0] pc,
    output logic                            pc_advance,
    output logic                            pc_load,
    input  logic                            line_hit,
    output logic                            buffer_fill,
    input  logic                            inst_ready,
    input  logic                            redirect_valid,
    output logic                            inst_valid
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    // Tag of the fetch in flight, zero when nothing is owed to us
    mem_bus_pkg::mem_tag_t kept_tag;

    logic issue;
    logic accepted;
    logic reply_match;
    logic transfer;

    //////////////////////////////////////////////////
    // Bus request
    //////////////////////////////////////////////////

    // Only ask for the line if the buffer does not already hold it
    // No new request in a redirect cycle, the PC is about to change
    assign issue = (state == fetch_pkg::request) && !line_hit && !redirect_valid;

    assign bus.cmd   = issue ? mem_bus_pkg::bus_load : mem_bus_pkg::bus_none;
    // Line aligned address
    assign bus.addr  = {pc[fetch_pkg::ADDR_BITS-1:3], 3'b000};
    assign bus.wdata = '0;

    // Busy answer is a zero tag, so keep driving until nonzero
    assign accepted = issue && (bus.accept_tag != '0);

    // Stale replies carry an old tag and never match
    assign reply_match = (state == fetch_pkg::wait_data)
                      && bus.reply_valid
                      && (bus.reply_tag == kept_tag);

    assign buffer_fill = reply_match;

    //////////////////////////////////////////////////
    // Instruction handshake
    //////////////////////////////////////////////////

    // Valid only while the buffered line covers the PC
    assign inst_valid = (state == fetch_pkg::deliver) && line_hit;

    // Redirect wins, a transfer in that cycle is not counted
    assign transfer   = inst_valid && inst_ready && !redirect_valid;
    assign pc_advance = transfer;
    assign pc_load    = redirect_valid;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::request: begin
                // Redirect back into the buffered line needs no bus trip
                if (line_hit) begin
                    state_next = fetch_pkg::deliver;
                end else if (accepted) begin
                    state_next = fetch_pkg::wait_data;
                end
            end
            fetch_pkg::wait_data: begin
                if (reply_match) begin
                    state_next = fetch_pkg::deliver;
                end
            end
            fetch_pkg::deliver: begin
                // Second slot of the line stays here, next line goes out
                if (!line_hit) begin
                    state_next = fetch_pkg::request;
                end
            end
            default: begin
                state_next = fetch_pkg::request;
            end
        endcase
        // Flush from any state
        if (redirect_valid) begin
            state_next = fetch_pkg::request;
        end
    end

    // Reset lands in deliver with an empty buffer
    // so the bus stays quiet until the first cycle after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= fetch_pkg::deliver;
            kept_tag <= '0;
        end else begin
            state <= state_next;
            if (redirect_valid) begin
                kept_tag <= '0;
            end else if (accepted) begin
                kept_tag <= bus.accept_tag;
            end
        end
    end

endmodule

// ==== design/mem_req_if.sv ====
// One requester's link to the memory selector:
// request, acceptance tag and tagged reply
`timescale 1ns/1ps

interface mem_req_if;

    // Request side
    mem_bus_pkg::bus_cmd_t              cmd;
    logic [fetch_pkg::ADDR_BITS-1:0]    addr;
    mem_bus_pkg::mem_line_u             wdata;

    // Bus side
    // Accept tag is nonzero only for the requester that won the bus
    mem_bus_pkg::mem_tag_t              accept_tag;
    // Reply valid excludes load replies
    logic                               reply_valid;
    mem_bus_pkg::mem_tag_t              reply_tag;
    mem_bus_pkg::mem_line_u             reply_line;

    modport requester (
        output cmd, addr, wdata,
        input  accept_tag, reply_valid, reply_tag, reply_line
    );

    modport bus (
        input  cmd, addr, wdata,
        output accept_tag, reply_valid, reply_tag, reply_line
    );

endinterface

// ==== design/fetch_pkg.sv ====
// Fetch definitions: address width, instruction word,
// controller state type and the packet handed out per instruction
package fetch_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////

    // Byte address width
    parameter int ADDR_BITS = 32;

    // One instruction word
    typedef logic [31:0] inst_t;

    //////////////////////////////////////////////////
    // Controller state and output packet
    //////////////////////////////////////////////////

    // Fetch controller states
    // request   = line load on the bus until a tag comes back
    // wait_data = waiting for the reply with the kept tag
    // deliver   = instruction presented from the line buffer
    typedef enum logic [1:0] {
        request   = 2'h0,
        wait_data = 2'h1,
        deliver   = 2'h2
    } fetch_state_t;

    // Instruction with its own PC, 64 bits in all
    typedef struct packed {
        inst_t                 inst;
        logic [ADDR_BITS-1:0]  pc;
    } fetch_packet_t;

endpackage

// ==== design/mem_bus_pkg.sv ====
// Memory bus definitions: command and tag types, line width,
// and the line union shared by loads and instruction fetch
package mem_bus_pkg;

    //////////////////////////////////////////////////
    // Bus command and tag
    //////////////////////////////////////////////////

    // Command driven toward memory, two bits on the wire
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    // Transaction tag
    // Zero on mem_response means busy, zero on mem_tag means no reply
    typedef logic [3:0] mem_tag_t;

    //////////////////////////////////////////////////
    // Memory line
    //////////////////////////////////////////////////

    // One memory line is one doubleword
    parameter int LINE_BITS = 64;

    // Loads see the line as one doubleword,
    // fetch sees it as two instruction slots
    // Slot 0 sits at the lower address (bits 31:0)
    typedef union packed {
        logic [LINE_BITS-1:0]                dword;
        logic [1:0][(LINE_BITS/2)-1:0]       slot;
    } mem_line_u;

endpackage
